// ==== src/rvPkg.sv ====
package rvPkg;

	// data path width, fixed for RV32I
	localparam int XLEN = 32;

	// one data or instruction word
	typedef logic [XLEN-1:0] wordT;
	// architectural register index
	typedef logic [4:0] regIdT;

	// major opcodes, inst[6:0]
	localparam logic [6:0] opcOp    = 7'b0110011;
	localparam logic [6:0] opcOpImm = 7'b0010011;
	localparam logic [6:0] opcLui   = 7'b0110111;
	localparam logic [6:0] opcLoad  = 7'b0000011;
	localparam logic [6:0] opcStore = 7'b0100011;

	// alu function, passB serves lui
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluPassB
	} aluOpT;

	// memory stage action
	typedef enum logic [2:0] {
		memNone,
		memLoadWord,
		memLoadByte,
		memLoadByteU,
		memStoreWord
	} memOpT;

	// ID/EX stage register contents
	typedef struct packed {
		logic  valid;
		logic  illegal;
		logic  regWen;
		regIdT rd;
		regIdT rs1;
		regIdT rs2;
		aluOpT aluOp;
		memOpT memOp;
		logic  useImm;
		wordT  imm;
		wordT  rdata1;
		wordT  rdata2;
	} idExT;

	// EX/MEM stage register contents
	typedef struct packed {
		logic  valid;
		logic  illegal;
		logic  regWen;
		regIdT rd;
		memOpT memOp;
		// alu value, or byte address for loads and stores
		wordT  result;
		wordT  storeData;
	} exMemT;

	// forwarding bus from a later stage
	typedef struct packed {
		logic  valid;
		regIdT rd;
		wordT  data;
	} fwdT;

	// MEM/WB contents, also the writeback bus and retire fields
	typedef struct packed {
		logic  valid;
		logic  illegal;
		logic  regWen;
		regIdT rd;
		wordT  data;
	} retireT;

endpackage

// ==== src/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import rvPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  logic   instValid,
	input  wordT   inst,
	input  retireT wb,
	output idExT   idEx
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	regIdT rdIdx;
	regIdT rs1Idx;
	regIdT rs2Idx;
	wordT immI;
	wordT immS;
	wordT immU;
	idExT idExNext;
	// x1..x31, x0 is hardwired
	wordT regs [1:31];

	// field split
	assign opcode = inst[6:0];
	assign rdIdx  = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1Idx = inst[19:15];
	assign rs2Idx = inst[24:20];
	assign funct7 = inst[31:25];

	// immediates, sign extended from bit 31
	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immU = {inst[31:12], 12'b0};

	// read port, the writeback value wins on a same-cycle hit
	function automatic wordT readReg(input regIdT idx);
		wordT val;
		if (idx == '0)
			val = '0;
		else if (wb.valid && wb.regWen && wb.rd == idx)
			val = wb.data;
		else
			val = regs[idx];
		return val;
	endfunction

	always_comb begin
		logic bad;
		bad = 1'b0;
		idExNext = '0;
		idExNext.valid = instValid;
		idExNext.rd = rdIdx;
		idExNext.rs1 = rs1Idx;
		idExNext.rs2 = rs2Idx;
		idExNext.aluOp = aluAdd;
		idExNext.memOp = memNone;
		idExNext.imm = immI;
		idExNext.rdata1 = readReg(rs1Idx);
		idExNext.rdata2 = readReg(rs2Idx);
		case (opcode)
			opcOp: begin
				idExNext.regWen = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'h0}: idExNext.aluOp = aluAdd;
					{7'h20, 3'h0}: idExNext.aluOp = aluSub;
					{7'h00, 3'h1}: idExNext.aluOp = aluSll;
					{7'h00, 3'h2}: idExNext.aluOp = aluSlt;
					{7'h00, 3'h3}: idExNext.aluOp = aluSltu;
					{7'h00, 3'h4}: idExNext.aluOp = aluXor;
					{7'h00, 3'h5}: idExNext.aluOp = aluSrl;
					{7'h20, 3'h5}: idExNext.aluOp = aluSra;
					{7'h00, 3'h6}: idExNext.aluOp = aluOr;
					{7'h00, 3'h7}: idExNext.aluOp = aluAnd;
					default: bad = 1'b1;
				endcase
			end
			opcOpImm: begin
				idExNext.regWen = 1'b1;
				idExNext.useImm = 1'b1;
				case (funct3)
					3'h0: idExNext.aluOp = aluAdd;
					3'h2: idExNext.aluOp = aluSlt;
					3'h3: idExNext.aluOp = aluSltu;
					3'h4: idExNext.aluOp = aluXor;
					3'h6: idExNext.aluOp = aluOr;
					3'h7: idExNext.aluOp = aluAnd;
					// shifts need a clean funct7
					3'h1: begin
						idExNext.aluOp = aluSll;
						bad = (funct7 != 7'h00);
					end
					default: begin
						idExNext.aluOp = (funct7 == 7'h20) ? aluSra : aluSrl;
						bad = (funct7 != 7'h00) && (funct7 != 7'h20);
					end
				endcase
			end
			opcLui: begin
				idExNext.regWen = 1'b1;
				idExNext.useImm = 1'b1;
				idExNext.imm = immU;
				idExNext.aluOp = aluPassB;
			end
			opcLoad: begin
				idExNext.regWen = 1'b1;
				idExNext.useImm = 1'b1;
				case (funct3)
					3'h2: idExNext.memOp = memLoadWord;
					3'h0: idExNext.memOp = memLoadByte;
					3'h4: idExNext.memOp = memLoadByteU;
					default: bad = 1'b1;
				endcase
			end
			opcStore: begin
				// rd field holds imm bits here
				idExNext.rd = '0;
				idExNext.useImm = 1'b1;
				idExNext.imm = immS;
				idExNext.memOp = memStoreWord;
				bad = (funct3 != 3'h2);
			end
			default: bad = 1'b1;
		endcase
		// illegal ops flow through as harmless bubbles
		if (bad) begin
			idExNext.illegal = 1'b1;
			idExNext.regWen = 1'b0;
			idExNext.memOp = memNone;
			idExNext.rd = '0;
		end
	end

	// register file write from MEM/WB
	always_ff @(posedge clk) begin
		if (wb.valid && wb.regWen && wb.rd != '0)
			regs[wb.rd] <= wb.data;
	end

	// ID/EX stage register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			idEx <= '0;
		else
			idEx <= idExNext;
	end

	// illegal entries must never reach the register file
	assert property (@(posedge clk) disable iff (!arstN)
		(wb.valid && wb.illegal) |-> !wb.regWen)
		else $error("illegal instruction carries a register write");

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import rvPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  idExT   idEx,
	input  fwdT    memFwd,
	input  retireT wb,
	output exMemT  exMem
);

	wordT opA;
	wordT opB;
	wordT fwdB;
	wordT aluOut;
	logic [4:0] shamt;
	exMemT exMemNext;

	// operand select, MEM result first, then writeback, then decode read
	function automatic wordT pickOperand(
		input regIdT  idx,
		input wordT   readVal,
		input fwdT    mf,
		input retireT wbBus
	);
		wordT val;
		if (idx != '0 && mf.valid && mf.rd == idx)
			val = mf.data;
		else if (idx != '0 && wbBus.valid && wbBus.regWen && wbBus.rd == idx)
			val = wbBus.data;
		else
			val = readVal;
		return val;
	endfunction

	assign opA = pickOperand(idEx.rs1, idEx.rdata1, memFwd, wb);
	// rs2 value, also the store data
	assign fwdB = pickOperand(idEx.rs2, idEx.rdata2, memFwd, wb);
	assign opB = idEx.useImm ? idEx.imm : fwdB;
	// low five bits only, covers shamt in I-type too
	assign shamt = opB[4:0];

	always_comb begin
		case (idEx.aluOp)
			aluAdd:   aluOut = opA + opB;
			aluSub:   aluOut = opA - opB;
			aluAnd:   aluOut = opA & opB;
			aluOr:    aluOut = opA | opB;
			aluXor:   aluOut = opA ^ opB;
			aluSlt:   aluOut = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			aluSltu:  aluOut = {{(XLEN-1){1'b0}}, opA < opB};
			aluSll:   aluOut = opA << shamt;
			aluSrl:   aluOut = opA >> shamt;
			aluSra:   aluOut = wordT'($signed(opA) >>> shamt);
			aluPassB: aluOut = opB;
			default:  aluOut = '0;
		endcase
	end

	always_comb begin
		exMemNext.valid = idEx.valid;
		exMemNext.illegal = idEx.illegal;
		exMemNext.regWen = idEx.regWen;
		exMemNext.rd = idEx.rd;
		exMemNext.memOp = idEx.memOp;
		// address for loads and stores
		exMemNext.result = aluOut;
		exMemNext.storeData = fwdB;
	end

	// EX/MEM stage register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			exMem <= '0;
		else
			exMem <= exMemNext;
	end

	// rd drives both forwarding compares downstream
	assert property (@(posedge clk) disable iff (!arstN)
		exMem.valid |-> !$isunknown(exMem.rd))
		else $error("valid EX/MEM entry with unknown rd");

endmodule

// ==== src/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage import rvPkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input  logic   clk,
	input  logic   arstN,
	input  exMemT  exMem,
	output fwdT    memFwd,
	output retireT wb
);

	localparam int ADDR_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

	wordT mem [DMEM_WORDS];
	// per-word written flag, unwritten words read as zero
	logic [DMEM_WORDS-1:0] wordWritten;
	logic [ADDR_W-1:0] wordIdx;
	logic [1:0] lane;
	wordT rawWord;
	logic [7:0] byteVal;
	wordT wbData;
	logic storeEn;

	// word address wraps at the memory depth
	assign wordIdx = ADDR_W'((exMem.result >> 2) % DMEM_WORDS);
	assign lane = exMem.result[1:0];
	assign storeEn = exMem.valid && exMem.memOp == memStoreWord;

	// combinational read in the same cycle
	assign rawWord = wordWritten[wordIdx] ? mem[wordIdx] : '0;
	assign byteVal = rawWord[8*lane +: 8];

	// load extension, alu value for everything else
	always_comb begin
		case (exMem.memOp)
			memLoadWord:  wbData = rawWord;
			memLoadByte:  wbData = {{(XLEN-8){byteVal[7]}}, byteVal};
			memLoadByteU: wbData = {{(XLEN-8){1'b0}}, byteVal};
			default:      wbData = exMem.result;
		endcase
	end

	// forward to execute for back-to-back use
	assign memFwd.valid = exMem.valid && exMem.regWen;
	assign memFwd.rd = exMem.rd;
	assign memFwd.data = wbData;

	// whole-word store
	always_ff @(posedge clk) begin
		if (storeEn)
			mem[wordIdx] <= exMem.storeData;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			wordWritten <= '0;
		else if (storeEn)
			wordWritten[wordIdx] <= 1'b1;
	end

	// MEM/WB stage register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wb <= '0;
		end else begin
			wb.valid <= exMem.valid;
			wb.illegal <= exMem.illegal;
			wb.regWen <= exMem.regWen;
			wb.rd <= exMem.rd;
			wb.data <= wbData;
		end
	end

	// word accesses must be aligned
	assert property (@(posedge clk) disable iff (!arstN)
		(exMem.valid && (exMem.memOp == memLoadWord || exMem.memOp == memStoreWord))
		|-> exMem.result[1:0] == 2'b00)
		else $error("misaligned word access");

endmodule

// ==== src/rvPipe.sv ====
`timescale 1ns/1ps

module rvPipe import rvPkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input  logic  clk,
	input  logic  arstN,
	input  logic  instValid,
	input  wordT  inst,
	output logic  retireValid,
	output logic  retireIllegal,
	output regIdT retireRd,
	output wordT  retireData
);

	// IF/ID capture
	logic ifValid;
	wordT ifInst;
	idExT idEx;
	exMemT exMem;
	fwdT memFwd;
	retireT wb;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			ifValid <= 1'b0;
		else
			ifValid <= instValid;
	end

	always_ff @(posedge clk) begin
		ifInst <= inst;
	end

	decodeStage uDecode (
		.clk       (clk),
		.arstN     (arstN),
		.instValid (ifValid),
		.inst      (ifInst),
		.wb        (wb),
		.idEx      (idEx)
	);

	executeStage uExecute (
		.clk    (clk),
		.arstN  (arstN),
		.idEx   (idEx),
		.memFwd (memFwd),
		.wb     (wb),
		.exMem  (exMem)
	);

	memoryStage #(
		.DMEM_WORDS (DMEM_WORDS)
	) uMemory (
		.clk    (clk),
		.arstN  (arstN),
		.exMem  (exMem),
		.memFwd (memFwd),
		.wb     (wb)
	);

	// retire port
	// rd arrives already cleared from decode for non-writers
	assign retireValid = wb.valid;
	assign retireIllegal = wb.illegal;
	assign retireRd = wb.rd;
	// data zeroed when nothing is written
	assign retireData = wb.regWen ? wb.data : '0;

endmodule

// ==== sim/tbRvPipe.sv ====
`timescale 1ns/1ps

module tbRvPipe import rvPkg::*; #(
	parameter int DMEM_WORDS = 64
);

	localparam int PERIOD = 4;
	// drive edge to the negedge sample of the retire cycle
	localparam int LATENCY_NS = 4 * PERIOD + PERIOD / 2;
	localparam int N_ALU = 200;
	localparam int N_MEM = 120;
	localparam int N_PAIRS = 60;
	localparam int N_ILL = 40;
	localparam int N_X0 = 80;
	localparam int TOTAL = 1 + N_ALU + N_MEM + 2 * N_PAIRS + N_ILL + N_X0;
	localparam int WATCHDOG_NS = (TOTAL * 8 + 200) * PERIOD;

	// expected retire fields plus the drive time
	typedef struct packed {
		logic        illegal;
		regIdT       rd;
		wordT        data;
		logic [63:0] issueTime;
	} expectT;

	logic clk;
	logic arstN;
	logic instValid;
	wordT inst;
	logic retireValid;
	logic retireIllegal;
	regIdT retireRd;
	wordT retireData;

	logic [31:0] lfsr;
	wordT modelRegs [0:31];
	wordT modelMem [0:DMEM_WORDS-1];
	expectT expQ [$];
	int errorCount;
	int checkCount;
	int retireCount;
	int testCount;
	int errorsAtStart;

	rvPipe #(
		.DMEM_WORDS (DMEM_WORDS)
	) uut (
		.clk           (clk),
		.arstN         (arstN),
		.instValid     (instValid),
		.inst          (inst),
		.retireValid   (retireValid),
		.retireIllegal (retireIllegal),
		.retireRd      (retireRd),
		.retireData    (retireData)
	);

	always #(PERIOD / 2) clk = ~clk;

	// galois lfsr, one step per bit taken
	function automatic wordT randBits(input int n);
		wordT val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return val;
	endfunction

	task automatic checkValue(input string what, input wordT got, input wordT exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// reference result from the RV32I funct3 table
	function automatic wordT aluRef(input logic [2:0] f3, input logic alt, input wordT a,
		input wordT b);
		wordT r;
		case (f3)
			3'h0: r = alt ? a - b : a + b;
			3'h1: r = a << b[4:0];
			3'h2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'h3: r = (a < b) ? 32'd1 : 32'd0;
			3'h4: r = a ^ b;
			3'h5: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'h6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// architectural model, runs each accepted word in issue order
	task automatic modelExec(input wordT w);
		logic [2:0] f3;
		logic [6:0] f7;
		wordT a;
		wordT immI;
		wordT addr;
		wordT val;
		logic [7:0] bv;
		logic writes;
		logic bad;
		int idx;
		expectT e;
		f3 = w[14:12];
		f7 = w[31:25];
		a = modelRegs[w[19:15]];
		immI = {{20{w[31]}}, w[31:20]};
		writes = 1'b1;
		bad = 1'b0;
		val = '0;
		case (w[6:0])
			7'b0110011: begin
				bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'h0 || f3 == 3'h5)));
				val = aluRef(f3, f7[5], a, modelRegs[w[24:20]]);
			end
			7'b0010011: begin
				if (f3 == 3'h1)
					bad = (f7 != 7'h00);
				if (f3 == 3'h5)
					bad = (f7 != 7'h00 && f7 != 7'h20);
				// bit 30 only selects sra among the immediate forms
				val = aluRef(f3, f3 == 3'h5 && f7[5], a, immI);
			end
			7'b0110111: val = {w[31:12], 12'h000};
			7'b0000011: begin
				addr = a + immI;
				idx = int'((addr >> 2) % DMEM_WORDS);
				bv = 8'(modelMem[idx] >> (8 * addr[1:0]));
				if (f3 == 3'h2)
					val = modelMem[idx];
				else if (f3 == 3'h0)
					val = {{24{bv[7]}}, bv};
				else if (f3 == 3'h4)
					val = {24'h0, bv};
				else
					bad = 1'b1;
			end
			7'b0100011: begin
				writes = 1'b0;
				addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
				idx = int'((addr >> 2) % DMEM_WORDS);
				bad = (f3 != 3'h2);
				if (!bad)
					modelMem[idx] = modelRegs[w[24:20]];
			end
			default: bad = 1'b1;
		endcase
		if (bad)
			writes = 1'b0;
		if (writes && w[11:7] != 5'd0)
			modelRegs[w[11:7]] = val;
		e.illegal = bad;
		e.rd = writes ? w[11:7] : 5'd0;
		e.data = writes ? val : 32'd0;
		e.issueTime = $time;
		expQ.push_back(e);
	endtask

	// alu op, register or immediate form, or lui
	function automatic wordT genAlu(input logic rdZero);
		logic [2:0] f3;
		logic [11:0] imm;
		regIdT rd;
		regIdT rs1;
		wordT sel;
		f3 = 3'(randBits(3));
		rd = rdZero ? 5'd0 : 5'(randBits(3));
		rs1 = 5'(randBits(3));
		sel = randBits(3);
		if (sel == 0)
			return {20'(randBits(20)), rd, opcLui};
		if (sel < 5)
			return {((f3 == 3'h0 || f3 == 3'h5) && randBits(1) != 0) ? 7'h20 : 7'h00,
				5'(randBits(3)), rs1, f3, rd, opcOp};
		if (f3 == 3'h1)
			imm = {7'h00, 5'(randBits(5))};
		else if (f3 == 3'h5)
			imm = {(randBits(1) != 0) ? 7'h20 : 7'h00, 5'(randBits(5))};
		else
			imm = 12'(randBits(12));
		return {imm, rs1, f3, rd, opcOpImm};
	endfunction

	// x0-based lw, lb or lbu inside the memory range
	function automatic wordT genLoad(input regIdT rd);
		wordT kind;
		logic [11:0] imm;
		kind = randBits(2) % 3;
		imm = 12'(randBits(16) % (DMEM_WORDS * 4));
		if (kind == 0)
			return {imm & 12'hffc, 5'd0, 3'h2, rd, opcLoad};
		return {imm, 5'd0, (kind == 1) ? 3'h0 : 3'h4, rd, opcLoad};
	endfunction

	function automatic wordT genStore();
		logic [11:0] imm;
		imm = 12'((randBits(16) % DMEM_WORDS) * 4);
		return {imm[11:5], 5'(randBits(3)), 5'd0, 3'h2, imm[4:0], opcStore};
	endfunction

	// opcodes outside the supported subset
	function automatic wordT genIllegal();
		logic [6:0] opc;
		case (randBits(3) % 5)
			0: opc = 7'b1100011;
			1: opc = 7'b1101111;
			2: opc = 7'b1100111;
			3: opc = 7'b1110011;
			default: opc = 7'b0010111;
		endcase
		return {25'(randBits(25)), opc};
	endfunction

	task automatic issue(input wordT w);
		@(posedge clk);
		instValid <= 1'b1;
		inst <= w;
		modelExec(w);
	endtask

	task automatic idle();
		@(posedge clk);
		instValid <= 1'b0;
		inst <= randBits(32);
	endtask

	// roughly one idle cycle in four
	task automatic maybeGap();
		if (randBits(2) == 0)
			idle();
	endtask

	task automatic endTest(input string name, input int n);
		idle();
		// the queue drains at falling edges, so look at rising ones
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (2) idle();
		testCount++;
		$display("test %0d %s: %0d instructions, %0d errors", testCount, name, n,
			errorCount - errorsAtStart);
		errorsAtStart = errorCount;
	endtask

	// retire checker, outputs are stable at the falling edge
	always @(negedge clk) begin : retireMonitor
		expectT e;
		if (arstN && retireValid) begin
			retireCount++;
			if (expQ.size() == 0) begin
				errorCount++;
				$display("ERROR at %0d ns: a retire came out with no instruction in flight",
					$time);
			end else begin
				e = expQ.pop_front();
				checkValue("retireIllegal", 32'(retireIllegal), 32'(e.illegal));
				checkValue("retireRd", 32'(retireRd), 32'(e.rd));
				checkValue("retireData", retireData, e.data);
				checkValue("retire latency ns", 32'($time - e.issueTime), 32'(LATENCY_NS));
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin : mainSequence
		regIdT ldRd;
		clk = 1'b0;
		arstN <= 1'b0;
		instValid <= 1'b0;
		inst <= '0;
		lfsr = 32'd13431;
		errorCount = 0;
		checkCount = 0;
		retireCount = 0;
		testCount = 0;
		errorsAtStart = 0;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			modelMem[i] = '0;
		repeat (5) @(posedge clk);
		arstN <= 1'b1;

		// quiet pipeline, then a single addi x1, x0, 5
		repeat (8) idle();
		issue({12'd5, 5'd0, 3'h0, 5'd1, opcOpImm});
		endTest("reset and latency", 1);

		for (int i = 0; i < N_ALU; i++) begin
			maybeGap();
			issue(genAlu(1'b0));
		end
		endTest("alu hazards", N_ALU);

		for (int i = 0; i < N_MEM; i++) begin
			maybeGap();
			if (randBits(1) != 0)
				issue(genStore());
			else
				issue(genLoad(5'(randBits(3))));
		end
		endTest("store and load", N_MEM);

		// consumer follows its load with no gap
		for (int i = 0; i < N_PAIRS; i++) begin
			maybeGap();
			ldRd = 5'(1 + randBits(3) % 7);
			issue(genLoad(ldRd));
			if (randBits(1) != 0)
				issue({7'h00, 5'(randBits(3)), ldRd, 3'(randBits(3)), 5'(randBits(3)), opcOp});
			else
				issue({7'h00, ldRd, 5'(randBits(3)), 3'(randBits(3)), 5'(randBits(3)), opcOp});
		end
		endTest("load use", 2 * N_PAIRS);

		for (int i = 0; i < N_ILL; i++) begin
			maybeGap();
			if (randBits(1) != 0)
				issue(genIllegal());
			else
				issue(genAlu(1'b0));
		end
		endTest("illegal opcodes", N_ILL);

		for (int i = 0; i < N_X0; i++) begin
			if (randBits(1) != 0)
				idle();
			issue(genAlu(randBits(1) != 0));
		end
		endTest("x0 writes and gaps", N_X0);

		$display("%0d tests, %0d retires, %0d checks, %0d errors", testCount, retireCount,
			checkCount, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== tb.f ====
src/rvPkg.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/rvPipe.sv
sim/tbRvPipe.sv

// ==== Makefile ====
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tbRvPipe
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= STATUS: PASS

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
